// ==== source/rv_exec_pkg.sv ====
package rv_exec_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int HIS_LEN   = 8;
  localparam int CNT_W     = 16;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [XLEN-1:0]      imm_t;     // already sign extended by decode
  typedef logic [3:0]           alu_op_t;
  typedef logic [3:0]           exc_op_t;
  typedef logic [1:0]           jump_type_t;
  typedef logic [HIS_LEN-1:0]   history_t;
  typedef logic [CNT_W-1:0]     cnt_t;
  typedef logic [1:0]           opsel_a_t;
  typedef logic [1:0]           opsel_b_t;

  // alu ops, arithmetic and logic first
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;
  // branch compares
  localparam alu_op_t ALU_EQ   = 4'd10;
  localparam alu_op_t ALU_NE   = 4'd11;
  localparam alu_op_t ALU_LT   = 4'd12;
  localparam alu_op_t ALU_GE   = 4'd13;
  localparam alu_op_t ALU_LTU  = 4'd14;
  localparam alu_op_t ALU_GEU  = 4'd15;

  // execute classes
  localparam exc_op_t EXC_NONE   = 4'd0;
  localparam exc_op_t EXC_OPREG  = 4'd1;
  localparam exc_op_t EXC_OPIMM  = 4'd2;
  localparam exc_op_t EXC_LOAD   = 4'd3;
  localparam exc_op_t EXC_STORE  = 4'd4;
  localparam exc_op_t EXC_BRANCH = 4'd5;
  localparam exc_op_t EXC_JAL    = 4'd6;
  localparam exc_op_t EXC_JALR   = 4'd7;
  localparam exc_op_t EXC_LUI    = 4'd8;
  localparam exc_op_t EXC_AUIPC  = 4'd9;

  localparam jump_type_t JT_NONE   = 2'd0;
  localparam jump_type_t JT_JAL    = 2'd1;
  localparam jump_type_t JT_JALR   = 2'd2;
  localparam jump_type_t JT_BRANCH = 2'd3;

  localparam opsel_a_t SEL_A_RS1  = 2'd0;
  localparam opsel_a_t SEL_A_PC   = 2'd1;
  localparam opsel_a_t SEL_A_ZERO = 2'd2;

  localparam opsel_b_t SEL_B_RS2   = 2'd0;
  localparam opsel_b_t SEL_B_IMM   = 2'd1;
  localparam opsel_b_t SEL_B_FOUR  = 2'd2;
  localparam opsel_b_t SEL_B_UPPER = 2'd3;

endpackage

// ==== source/exu_ctrl.sv ====
module exu_ctrl import rv_exec_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     req_i,
  input  xlen_t    inst_addr_i,
  input  xlen_t    rs1_data_i,
  input  xlen_t    rs2_data_i,
  input  imm_t     imm_data_i,
  input  alu_op_t  alu_op_i,
  input  exc_op_t  exc_op_i,
  input  reg_idx_t rd_idx_i,
  input  logic     pdt_res_i,
  input  xlen_t    pdt_tag_i,
  input  logic     which_pdt_i,
  input  history_t history_i,
  output logic     ack_o,
  output logic     resolve_stb_o,
  output xlen_t    pc_o,
  output xlen_t    rs1_o,
  output xlen_t    rs2_o,
  output imm_t     imm_o,
  output alu_op_t  alu_op_o,
  output exc_op_t  exc_op_o,
  output reg_idx_t rd_idx_o,
  output logic     pred_taken_o,
  output opsel_a_t sel_a_o,
  output opsel_b_t sel_b_o,
  output logic     which_pdt_o,
  output history_t history_o
);

  typedef enum logic [1:0] {IDLE, EXEC, ACK} state_t;

  state_t state_q;
  logic   accept;

  assign accept        = (state_q == IDLE) && req_i;
  assign resolve_stb_o = (state_q == EXEC);  // datapath settles from captured regs
  assign ack_o         = (state_q == ACK);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (req_i) state_q <= EXEC;
        EXEC:    state_q <= ACK;
        ACK:     if (!req_i) state_q <= IDLE;  // four-phase return to zero
        default: state_q <= IDLE;
      endcase
    end
  end

  // instruction capture
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pc_o         <= inst_addr_i;
      rs1_o        <= rs1_data_i;
      rs2_o        <= rs2_data_i;
      imm_o        <= imm_data_i;
      alu_op_o     <= alu_op_i;
      exc_op_o     <= exc_op_i;
      rd_idx_o     <= rd_idx_i;
      pred_taken_o <= pdt_res_i && (pdt_tag_i == inst_addr_i);  // stale tag counts as not taken
      which_pdt_o  <= which_pdt_i;
      history_o    <= history_i;
    end
  end

  always_comb begin
    sel_a_o = SEL_A_RS1;
    sel_b_o = SEL_B_RS2;
    case (exc_op_o)
      EXC_OPIMM, EXC_LOAD, EXC_STORE: sel_b_o = SEL_B_IMM;
      EXC_JAL, EXC_JALR: begin  // link address
        sel_a_o = SEL_A_PC;
        sel_b_o = SEL_B_FOUR;
      end
      EXC_AUIPC: begin
        sel_a_o = SEL_A_PC;
        sel_b_o = SEL_B_UPPER;
      end
      EXC_LUI: begin
        sel_a_o = SEL_A_ZERO;
        sel_b_o = SEL_B_UPPER;
      end
      default: ;  // register class and branches use rs1, rs2
    endcase
  end

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_o) |-> $past(req_i));

  a_ack_drops: assert property (@(posedge clk_i) disable iff (reset_i)
    (ack_o && !req_i) |=> !ack_o);

endmodule

// ==== source/operand_mux.sv ====
module operand_mux import rv_exec_pkg::*; (
  input  opsel_a_t sel_a_i,
  input  opsel_b_t sel_b_i,
  input  xlen_t    pc_i,
  input  xlen_t    rs1_i,
  input  xlen_t    rs2_i,
  input  imm_t     imm_i,
  output xlen_t    alu_a_o,
  output xlen_t    alu_b_o
);

  xlen_t upper_imm;

  // lui and auipc keep only imm[31:12]
  assign upper_imm = {imm_i[XLEN-1:12], 12'b0};

  always_comb begin
    case (sel_a_i)
      SEL_A_RS1: alu_a_o = rs1_i;
      SEL_A_PC:  alu_a_o = pc_i;
      default:   alu_a_o = '0;
    endcase
  end

  always_comb begin
    case (sel_b_i)
      SEL_B_RS2:  alu_b_o = rs2_i;
      SEL_B_IMM:  alu_b_o = imm_i;
      SEL_B_FOUR: alu_b_o = xlen_t'(4);  // next sequential pc
      default:    alu_b_o = upper_imm;
    endcase
  end

endmodule

// ==== source/alu.sv ====
module alu import rv_exec_pkg::*; (
  input  xlen_t   alu_a_i,
  input  xlen_t   alu_b_i,
  input  alu_op_t alu_op_i,
  output xlen_t   alu_out_o,
  output logic    compare_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = alu_b_i[4:0];  // rv32 uses low five bits only
  assign lt_s  = $signed(alu_a_i) < $signed(alu_b_i);
  assign lt_u  = alu_a_i < alu_b_i;
  assign eq    = alu_a_i == alu_b_i;

  // compare flag for branches
  always_comb begin
    case (alu_op_i)
      ALU_EQ:  compare_o = eq;
      ALU_NE:  compare_o = !eq;
      ALU_LT:  compare_o = lt_s;
      ALU_GE:  compare_o = !lt_s;
      ALU_LTU: compare_o = lt_u;
      ALU_GEU: compare_o = !lt_u;
      default: compare_o = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_out_o = alu_a_i + alu_b_i;
      ALU_SUB:  alu_out_o = alu_a_i - alu_b_i;
      ALU_SLL:  alu_out_o = alu_a_i << shamt;
      ALU_SLT:  alu_out_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: alu_out_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  alu_out_o = alu_a_i ^ alu_b_i;
      ALU_SRL:  alu_out_o = alu_a_i >> shamt;
      ALU_SRA:  alu_out_o = xlen_t'($signed(alu_a_i) >>> shamt);
      ALU_OR:   alu_out_o = alu_a_i | alu_b_i;
      ALU_AND:  alu_out_o = alu_a_i & alu_b_i;
      ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU: begin
        alu_out_o = {{(XLEN-1){1'b0}}, compare_o};  // flag as data
      end
      default:  alu_out_o = '0;
    endcase
  end

endmodule

// ==== source/branch_resolve.sv ====
module branch_resolve import rv_exec_pkg::*; (
  input  exc_op_t    exc_op_i,
  input  xlen_t      pc_i,
  input  xlen_t      rs1_i,
  input  imm_t       imm_i,
  input  logic       compare_i,
  input  logic       pred_taken_i,
  input  logic       resolve_stb_i,
  output logic       is_branch_o,
  output logic       taken_o,
  output logic       mispredict_o,
  output logic       pdt_correct_o,
  output xlen_t      redirect_pc_o,
  output jump_type_t jump_type_o
);

  logic  is_jal;
  logic  is_jalr;
  logic  is_cond;
  xlen_t jalr_target;

  assign is_jal  = (exc_op_i == EXC_JAL);
  assign is_jalr = (exc_op_i == EXC_JALR);
  assign is_cond = (exc_op_i == EXC_BRANCH);

  assign is_branch_o = is_cond | is_jal | is_jalr;
  assign taken_o     = is_jal | is_jalr | (is_cond & compare_i);

  // also flags a non-branch that the predictor wrongly took
  assign mispredict_o  = taken_o != pred_taken_i;
  assign pdt_correct_o = taken_o & pred_taken_i;

  assign jalr_target = (rs1_i + imm_i) & ~xlen_t'(1);

  always_comb begin
    if (pred_taken_i && !taken_o) begin
      redirect_pc_o = pc_i + xlen_t'(4);  // fall through
    end else if (is_jalr) begin
      redirect_pc_o = jalr_target;
    end else begin
      redirect_pc_o = pc_i + imm_i;
    end
  end

  always_comb begin
    if (is_jal) begin
      jump_type_o = JT_JAL;
    end else if (is_jalr) begin
      jump_type_o = JT_JALR;
    end else if (is_cond) begin
      jump_type_o = JT_BRANCH;
    end else begin
      jump_type_o = JT_NONE;
    end
  end

  // sampled as the strobe ends, captured operands are still held then
  a_none_no_redirect: assert property (@(negedge resolve_stb_i)
    (exc_op_i == EXC_NONE && !pred_taken_i) |-> !mispredict_o);

endmodule

// ==== source/branch_stats.sv ====
module branch_stats import rv_exec_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic resolve_stb_i,
  input  logic is_branch_i,
  input  logic mispredict_i,
  output cnt_t branch_count_o,
  output cnt_t correct_count_o
);

  logic count_en;

  assign count_en = resolve_stb_i && is_branch_i;

  // both counters wrap on overflow
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      branch_count_o  <= '0;
      correct_count_o <= '0;
    end else if (count_en) begin
      branch_count_o <= branch_count_o + cnt_t'(1);
      if (!mispredict_i) begin
        correct_count_o <= correct_count_o + cnt_t'(1);
      end
    end
  end

endmodule

// ==== source/rv_exec.sv ====
module rv_exec import rv_exec_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       req_i,
  input  xlen_t      inst_addr_i,
  input  xlen_t      rs1_data_i,
  input  xlen_t      rs2_data_i,
  input  imm_t       imm_data_i,
  input  alu_op_t    alu_op_i,
  input  exc_op_t    exc_op_i,
  input  reg_idx_t   rd_idx_i,
  input  logic       pdt_res_i,
  input  xlen_t      pdt_tag_i,
  input  logic       which_pdt_i,
  input  history_t   history_i,
  output logic       ack_o,
  output xlen_t      alu_data_o,
  output reg_idx_t   rd_idx_o,
  output logic       bpu_valid_o,
  output logic       branch_taken_o,
  output logic       pdt_correct_o,
  output logic       which_pdt_o,
  output history_t   history_o,
  output jump_type_t jump_type_o,
  output xlen_t      redirect_pc_o,
  output logic       redirect_valid_o,
  output cnt_t       branch_count_o,
  output cnt_t       correct_count_o
);

  logic       resolve_stb;
  xlen_t      pc;
  xlen_t      rs1;
  xlen_t      rs2;
  imm_t       imm;
  alu_op_t    alu_op;
  exc_op_t    exc_op;
  logic       pred_taken;
  opsel_a_t   sel_a;
  opsel_b_t   sel_b;
  xlen_t      alu_a;
  xlen_t      alu_b;
  xlen_t      alu_out;
  logic       compare;
  logic       is_branch;
  logic       taken;
  logic       mispredict;
  logic       pdt_correct;
  xlen_t      redirect_pc;
  jump_type_t jump_type;
  logic       mispredict_q;

  exu_ctrl u_exu_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .inst_addr_i   (inst_addr_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .imm_data_i    (imm_data_i),
    .alu_op_i      (alu_op_i),
    .exc_op_i      (exc_op_i),
    .rd_idx_i      (rd_idx_i),
    .pdt_res_i     (pdt_res_i),
    .pdt_tag_i     (pdt_tag_i),
    .which_pdt_i   (which_pdt_i),
    .history_i     (history_i),
    .ack_o         (ack_o),
    .resolve_stb_o (resolve_stb),
    .pc_o          (pc),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .imm_o         (imm),
    .alu_op_o      (alu_op),
    .exc_op_o      (exc_op),
    .rd_idx_o      (rd_idx_o),     // held from capture until next request
    .pred_taken_o  (pred_taken),
    .sel_a_o       (sel_a),
    .sel_b_o       (sel_b),
    .which_pdt_o   (which_pdt_o),
    .history_o     (history_o)
  );

  operand_mux u_operand_mux (
    .sel_a_i (sel_a),
    .sel_b_i (sel_b),
    .pc_i    (pc),
    .rs1_i   (rs1),
    .rs2_i   (rs2),
    .imm_i   (imm),
    .alu_a_o (alu_a),
    .alu_b_o (alu_b)
  );

  alu u_alu (
    .alu_a_i   (alu_a),
    .alu_b_i   (alu_b),
    .alu_op_i  (alu_op),
    .alu_out_o (alu_out),
    .compare_o (compare)
  );

  branch_resolve u_branch_resolve (
    .exc_op_i      (exc_op),
    .pc_i          (pc),
    .rs1_i         (rs1),
    .imm_i         (imm),
    .compare_i     (compare),
    .pred_taken_i  (pred_taken),
    .resolve_stb_i (resolve_stb),
    .is_branch_o   (is_branch),
    .taken_o       (taken),
    .mispredict_o  (mispredict),
    .pdt_correct_o (pdt_correct),
    .redirect_pc_o (redirect_pc),
    .jump_type_o   (jump_type)
  );

  branch_stats u_branch_stats (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .resolve_stb_i   (resolve_stb),
    .is_branch_i     (is_branch),
    .mispredict_i    (mispredict),
    .branch_count_o  (branch_count_o),
    .correct_count_o (correct_count_o)
  );

  // result flags, loaded on the edge where ack rises
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bpu_valid_o    <= 1'b0;
      branch_taken_o <= 1'b0;
      pdt_correct_o  <= 1'b0;
      mispredict_q   <= 1'b0;
    end else if (resolve_stb) begin
      bpu_valid_o    <= is_branch;
      branch_taken_o <= taken;
      pdt_correct_o  <= pdt_correct;
      mispredict_q   <= mispredict;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resolve_stb) begin
      alu_data_o    <= alu_out;
      jump_type_o   <= jump_type;
      redirect_pc_o <= redirect_pc;
    end
  end

  assign redirect_valid_o = mispredict_q & ack_o;  // only while results are valid

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk_o
);

  // free running, period of 4
  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

// ==== testbench/tb_rv_exec.sv ====
module tb_rv_exec import rv_exec_pkg::*; ();

  localparam int WAIT_LIMIT = 20;  // edges before a handshake counts as stuck

  logic       clk_i;
  logic       reset_i;
  logic       req_i;
  xlen_t      inst_addr_i;
  xlen_t      rs1_data_i;
  xlen_t      rs2_data_i;
  imm_t       imm_data_i;
  alu_op_t    alu_op_i;
  exc_op_t    exc_op_i;
  reg_idx_t   rd_idx_i;
  logic       pdt_res_i;
  xlen_t      pdt_tag_i;
  logic       which_pdt_i;
  history_t   history_i;
  logic       ack_o;
  xlen_t      alu_data_o;
  reg_idx_t   rd_idx_o;
  logic       bpu_valid_o;
  logic       branch_taken_o;
  logic       pdt_correct_o;
  logic       which_pdt_o;
  history_t   history_o;
  jump_type_t jump_type_o;
  xlen_t      redirect_pc_o;
  logic       redirect_valid_o;
  cnt_t       branch_count_o;
  cnt_t       correct_count_o;

  // expected results, loaded with each request
  xlen_t      exp_alu;
  reg_idx_t   exp_rd;
  logic       exp_bpu_valid;
  logic       exp_taken;
  logic       exp_pdt_correct;
  logic       exp_which;
  history_t   exp_history;
  jump_type_t exp_jt;
  logic       exp_redirect;
  xlen_t      exp_redirect_pc;
  cnt_t       exp_branches;
  cnt_t       exp_correct;

  int errors;
  int tests;
  int txns;
  int test_start_errors;

  tb_clock_gen u_clock_gen (.clk_o(clk_i));

  rv_exec u_rv_exec (.*);

  task automatic report_value(input string sig, input xlen_t expv, input xlen_t actv);
    $display("error at %0t: %s expected %0h got %0h", $time, sig, expv, actv);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("failure at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Something failed");
    $finish;
  endtask

  // handshake shape
  a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(req_i) |-> !ack_o ##1 !ack_o ##1 ack_o)
    else report_problem("ack_o did not rise exactly two edges after req_i");
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (ack_o && req_i) |=> ack_o)
    else report_problem("ack_o dropped while req_i was still high");
  a_fall: assert property (@(posedge clk_i) disable iff (reset_i)
    (ack_o && !req_i) |=> !ack_o)
    else report_problem("ack_o did not fall one edge after req_i dropped");
  a_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (!ack_o && !redirect_valid_o && !bpu_valid_o && !branch_taken_o
                        && !pdt_correct_o && branch_count_o == '0 && correct_count_o == '0))
    else report_problem("outputs were not cleared by reset");

  // results while ack_o is high
  a_alu: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> alu_data_o == exp_alu)
    else report_value("alu_data_o", exp_alu, $sampled(alu_data_o));
  a_rd: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> rd_idx_o == exp_rd)
    else report_value("rd_idx_o", xlen_t'(exp_rd), xlen_t'($sampled(rd_idx_o)));
  a_bpu_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> bpu_valid_o == exp_bpu_valid)
    else report_value("bpu_valid_o", xlen_t'(exp_bpu_valid), xlen_t'($sampled(bpu_valid_o)));
  a_taken: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> branch_taken_o == exp_taken)
    else report_value("branch_taken_o", xlen_t'(exp_taken), xlen_t'($sampled(branch_taken_o)));
  a_pdt_correct: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> pdt_correct_o == exp_pdt_correct)
    else report_value("pdt_correct_o", xlen_t'(exp_pdt_correct),
                      xlen_t'($sampled(pdt_correct_o)));
  a_which: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> which_pdt_o == exp_which)
    else report_value("which_pdt_o", xlen_t'(exp_which), xlen_t'($sampled(which_pdt_o)));
  a_history: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> history_o == exp_history)
    else report_value("history_o", xlen_t'(exp_history), xlen_t'($sampled(history_o)));
  a_jump_type: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> jump_type_o == exp_jt)
    else report_value("jump_type_o", xlen_t'(exp_jt), xlen_t'($sampled(jump_type_o)));
  a_redirect: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> redirect_valid_o == exp_redirect)
    else report_value("redirect_valid_o", xlen_t'(exp_redirect),
                      xlen_t'($sampled(redirect_valid_o)));
  a_redirect_pc: assert property (@(posedge clk_i) disable iff (reset_i)
    (ack_o && exp_redirect) |-> redirect_pc_o == exp_redirect_pc)
    else report_value("redirect_pc_o", exp_redirect_pc, $sampled(redirect_pc_o));
  a_branches: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> branch_count_o == exp_branches)
    else report_value("branch_count_o", xlen_t'(exp_branches), xlen_t'($sampled(branch_count_o)));
  a_correct: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> correct_count_o == exp_correct)
    else report_value("correct_count_o", xlen_t'(exp_correct),
                      xlen_t'($sampled(correct_count_o)));

  // rv32 branch conditions
  function automatic logic cond_holds(input alu_op_t op, input xlen_t a, input xlen_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return $signed(a) >= $signed(b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic xlen_t alu_ref(input alu_op_t op, input xlen_t a, input xlen_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return {31'b0, cond_holds(op, a, b)};  // compare as 0 or 1
    endcase
  endfunction

  function automatic xlen_t rand_pc();
    return xlen_t'($urandom()) & 32'hffff_fffc;
  endfunction

  function automatic imm_t rand_imm();
    logic [11:0] r;
    r = 12'($urandom());
    return {{20{r[11]}}, r};
  endfunction

  task automatic run_txn(input exc_op_t exc, input alu_op_t op, input xlen_t pc,
                         input xlen_t a, input xlen_t b, input imm_t imm,
                         input logic pred_res, input logic tag_ok, input int hold);
    xlen_t    res;
    xlen_t    upper;
    logic     is_br;
    logic     pred;
    logic     tk;
    logic     miss;
    reg_idx_t rd;
    logic     which;
    history_t hist;
    int       cnt;
    upper = {imm[31:12], 12'h000};
    is_br = (exc == EXC_BRANCH) || (exc == EXC_JAL) || (exc == EXC_JALR);
    pred  = pred_res && tag_ok;
    tk    = (exc == EXC_JAL) || (exc == EXC_JALR) || (exc == EXC_BRANCH && cond_holds(op, a, b));
    miss  = tk != pred;
    rd    = reg_idx_t'($urandom());  // side fields pass through unchanged
    which = 1'($urandom());
    hist  = history_t'($urandom());
    case (exc)
      EXC_OPIMM, EXC_LOAD, EXC_STORE: res = alu_ref(op, a, imm);
      EXC_JAL, EXC_JALR:              res = pc + 32'd4;  // link value
      EXC_LUI:                        res = upper;
      EXC_AUIPC:                      res = pc + upper;
      default:                        res = alu_ref(op, a, b);
    endcase
    @(posedge clk_i);
    inst_addr_i     <= pc;
    rs1_data_i      <= a;
    rs2_data_i      <= b;
    imm_data_i      <= imm;
    alu_op_i        <= op;
    exc_op_i        <= exc;
    rd_idx_i        <= rd;
    pdt_res_i       <= pred_res;
    pdt_tag_i       <= tag_ok ? pc : pc ^ 32'h0000_0040;  // stale tag
    which_pdt_i     <= which;
    history_i       <= hist;
    exp_alu         <= res;
    exp_rd          <= rd;
    exp_which       <= which;
    exp_history     <= hist;
    exp_bpu_valid   <= is_br;
    exp_taken       <= tk;
    exp_pdt_correct <= tk && pred;
    exp_redirect    <= miss;
    exp_jt          <= (exc == EXC_JAL) ? JT_JAL : (exc == EXC_JALR) ? JT_JALR :
                       (exc == EXC_BRANCH) ? JT_BRANCH : JT_NONE;
    exp_redirect_pc <= (pred && !tk) ? pc + 32'd4 :
                       (exc == EXC_JALR) ? ((a + imm) & ~32'd1) : pc + imm;
    exp_branches    <= exp_branches + cnt_t'(is_br);
    exp_correct     <= exp_correct + cnt_t'(is_br && !miss);
    req_i           <= 1'b1;
    txns++;
    cnt = 0;
    while (!ack_o && cnt < WAIT_LIMIT) begin
      @(posedge clk_i);
      cnt++;
    end
    if (!ack_o) begin
      stop_on_timeout("ack_o never rose after req_i");
    end
    repeat (hold) @(posedge clk_i);  // requester holds req_i
    req_i <= 1'b0;
    cnt = 0;
    while (ack_o && cnt < WAIT_LIMIT) begin
      @(posedge clk_i);
      cnt++;
    end
    if (ack_o) begin
      stop_on_timeout("ack_o never fell after req_i dropped");
    end
  endtask

  task automatic run_random_txn();
    exc_op_t exc;
    alu_op_t op;
    xlen_t   a;
    exc = exc_op_t'($urandom_range(9, 0));
    op  = alu_op_t'($urandom_range(15, 0));
    a   = $urandom();
    if (exc == EXC_BRANCH) begin
      op = alu_op_t'($urandom_range(15, 10));
    end else if (exc inside {EXC_JAL, EXC_JALR, EXC_LUI, EXC_AUIPC, EXC_LOAD, EXC_STORE}) begin
      op = ALU_ADD;
    end
    run_txn(exc, op, rand_pc(), a, ($urandom_range(1, 0) != 0) ? a : xlen_t'($urandom()),
            rand_imm(), 1'($urandom()), 1'($urandom()), 0);
  endtask

  task automatic start_test();
    test_start_errors = errors;
  endtask

  task automatic finish_test(input string name);
    @(posedge clk_i);  // let the last checks report
    tests++;
    if (errors == test_start_errors) begin
      $display("test %0d %s: passed", tests, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests, name, errors - test_start_errors);
    end
  endtask

  initial begin
    xlen_t a;
    xlen_t b;
    void'($urandom(32'h9c7d_efc8));
    errors      = 0;
    tests       = 0;
    txns        = 0;
    reset_i     = 1'b1;
    req_i       = 1'b0;
    inst_addr_i = '0;
    rs1_data_i  = '0;
    rs2_data_i  = '0;
    imm_data_i  = '0;
    alu_op_i    = ALU_ADD;
    exc_op_i    = EXC_NONE;
    rd_idx_i    = '0;
    pdt_res_i   = 1'b0;
    pdt_tag_i   = '0;
    which_pdt_i = 1'b0;
    history_i   = '0;
    exp_branches = '0;
    exp_correct  = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    start_test();
    run_txn(EXC_OPREG, ALU_ADD, rand_pc(), $urandom(), $urandom(), rand_imm(), 1'b0, 1'b1, 0);
    run_txn(EXC_OPREG, ALU_XOR, rand_pc(), $urandom(), $urandom(), rand_imm(), 1'b0, 1'b1, 6);
    finish_test("reset and handshake");

    start_test();
    for (int op = 0; op < 16; op++) begin
      run_txn(EXC_OPREG, alu_op_t'(op), rand_pc(), $urandom(), $urandom(), rand_imm(),
              1'b0, 1'b1, 0);
      run_txn(EXC_OPIMM, alu_op_t'(op), rand_pc(), $urandom(), $urandom(), rand_imm(),
              1'b0, 1'b1, 0);
    end
    finish_test("alu results");

    start_test();
    run_txn(EXC_LUI, ALU_ADD, rand_pc(), $urandom(), $urandom(), $urandom(), 1'b0, 1'b1, 0);
    run_txn(EXC_AUIPC, ALU_ADD, rand_pc(), $urandom(), $urandom(), $urandom(), 1'b0, 1'b1, 0);
    run_txn(EXC_JAL, ALU_ADD, rand_pc(), $urandom(), $urandom(), rand_imm(), 1'b1, 1'b1, 0);
    run_txn(EXC_JALR, ALU_ADD, rand_pc(), $urandom(), $urandom(), rand_imm(), 1'b1, 1'b1, 0);
    finish_test("operand selection");

    start_test();
    for (int op = 10; op < 16; op++) begin
      for (int k = 0; k < 4; k++) begin
        a = $urandom();
        b = k[0] ? a : xlen_t'($urandom());  // equal operands half the time
        run_txn(EXC_BRANCH, alu_op_t'(op), rand_pc(), a, b, rand_imm(), k[1], 1'b1, 0);
      end
    end
    for (int p = 0; p < 2; p++) begin
      run_txn(EXC_JAL, ALU_ADD, rand_pc(), $urandom(), $urandom(), rand_imm(), p[0], 1'b1, 0);
      run_txn(EXC_JALR, ALU_ADD, rand_pc(), $urandom(), $urandom(), rand_imm(), p[0], 1'b1, 0);
    end
    run_txn(EXC_JAL, ALU_ADD, rand_pc(), $urandom(), $urandom(), rand_imm(), 1'b1, 1'b0, 0);
    run_txn(EXC_BRANCH, ALU_EQ, rand_pc(), 32'd7, 32'd7, rand_imm(), 1'b1, 1'b0, 0);
    finish_test("branch resolution");

    start_test();
    run_txn(EXC_OPREG, ALU_ADD, rand_pc(), $urandom(), $urandom(), rand_imm(), 1'b1, 1'b1, 0);
    run_txn(EXC_OPIMM, ALU_OR, rand_pc(), $urandom(), $urandom(), rand_imm(), 1'b1, 1'b1, 0);
    run_txn(EXC_LOAD, ALU_ADD, rand_pc(), $urandom(), $urandom(), rand_imm(), 1'b1, 1'b1, 0);
    run_txn(EXC_LUI, ALU_ADD, rand_pc(), $urandom(), $urandom(), $urandom(), 1'b0, 1'b1, 0);
    run_txn(EXC_BRANCH, ALU_NE, rand_pc(), 32'd1, 32'd2, rand_imm(), 1'b1, 1'b1, 0);
    run_txn(EXC_BRANCH, ALU_NE, rand_pc(), 32'd3, 32'd3, rand_imm(), 1'b0, 1'b1, 0);
    finish_test("predictor feedback");

    start_test();
    for (int i = 0; i < 24; i++) begin
      run_random_txn();
    end
    finish_test("statistics");

    $display("tests %0d, transactions %0d, errors %0d", tests, txns, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== rv_exec.f ====
source/rv_exec_pkg.sv
source/exu_ctrl.sv
source/operand_mux.sv
source/alu.sv
source/branch_resolve.sv
source/branch_stats.sv
source/rv_exec.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_exec.sv

// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - source/rv_exec_pkg.sv
  - source/exu_ctrl.sv
  - source/operand_mux.sv
  - source/alu.sv
  - source/branch_resolve.sv
  - source/branch_stats.sv
  - source/rv_exec.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_rv_exec.sv
